/* hw/icache_array_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if;

    import icache_cfg_pkg::*;

    logic                         rd_en;
    idx_t                         rd_idx;
    tag_t                         rd_tag;    // Compared against every way
    logic                         wr_en;
    idx_t                         wr_idx;
    tag_t                         wr_tag;
    way_vec_t                     wr_way;    // One-hot way to fill
    line_t                        wr_line;
    logic                         flush;
    way_vec_t                     hit;       // Valid the cycle after rd_en
    way_vec_t                     victim;    // Way to replace in the last read set
    line_t [ICACHE_N_WAY-1:0]     rd_lines;

    modport ctrl (
        output rd_en, rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_way, wr_line, flush,
        input  hit, victim, rd_lines
    );

    modport tag (
        input  rd_en, rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_way, flush,
        output hit, victim
    );

    modport data (
        input  rd_en, rd_idx, wr_en, wr_idx, wr_way, wr_line,
        output rd_lines
    );

endinterface

`default_nettype wire

/* hw/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

    localparam int ICACHE_N_WAY          = 2;
    localparam int ICACHE_N_SET          = 8;
    localparam int ICACHE_WORDS_PER_LINE = 4;

    localparam int ADDR_W = 16;                     // Physical byte address
    localparam int WORD_W = 32;
    localparam int LINE_W = ICACHE_WORDS_PER_LINE * WORD_W;

    localparam int IDX_W  = $clog2(ICACHE_N_SET);
    localparam int OFS_W  = $clog2(LINE_W / 8);     // Byte offset inside a line
    localparam int WSEL_W = $clog2(ICACHE_WORDS_PER_LINE);
    localparam int TAG_W  = ADDR_W - IDX_W - OFS_W;

    typedef logic [ADDR_W-1:0]       paddr_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [IDX_W-1:0]        idx_t;
    typedef logic [WSEL_W-1:0]       word_sel_t;    // Word within a line

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [ICACHE_N_WAY-1:0] way_vec_t;     // One bit per way

endpackage

`default_nettype wire

/* hw/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   ireq_valid_i,
    input  icache_cfg_pkg::paddr_t ireq_addr_i,
    input  logic                   ireq_kill_i,
    input  logic                   flush_i,
    output logic                   iresp_ready_o,
    output logic                   iresp_valid_o,
    output icache_cfg_pkg::word_t  iresp_data_o,
    output logic                   miss_o,
    output logic                   ifill_req_o,
    output icache_cfg_pkg::paddr_t ifill_addr_o,
    input  logic                   ifill_ack_i,
    input  icache_cfg_pkg::line_t  ifill_data_i,
    icache_array_if.ctrl           arr
);

    import icache_cfg_pkg::*;
    import icache_ctrl_pkg::*;

    ictrl_state_t state_d, state_q;

    paddr_t    addr_q;          // Address of the outstanding request
    way_vec_t  way_q;           // Victim picked at the miss
    logic      fill_done_q;     // Line already written for this fill
    logic      is_hit;
    logic      rd_en;
    logic      rd_replay;       // Read from addr_q instead of the core
    logic      wr_en;
    logic      flush_en;
    paddr_t    rd_addr;
    line_t     hit_line;

    assign is_hit = |arr.hit;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= READ;
            fill_done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) fill_done_q <= 1'b0;
            else if (wr_en)        fill_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en && !rd_replay) addr_q <= ireq_addr_i;
        if (state_q == LOOKUP && !is_hit) way_q <= arr.victim;
    end

    always_comb begin
        state_d       = state_q;
        iresp_ready_o = 1'b0;
        iresp_valid_o = 1'b0;
        miss_o        = 1'b0;
        ifill_req_o   = 1'b0;
        rd_en         = 1'b0;
        rd_replay     = 1'b0;
        wr_en         = 1'b0;
        flush_en      = 1'b0;
        case (state_q)
            READ: begin
                state_d       = (ireq_valid_i && !flush_i) ? LOOKUP : READ;
                iresp_ready_o = !flush_i;                    // A flush blocks the request
                rd_en         = ireq_valid_i && !flush_i;
                flush_en      = flush_i;
            end
            LOOKUP: begin
                state_d       = ireq_kill_i  ? READ   :
                                !is_hit      ? MISS   :
                                ireq_valid_i ? LOOKUP :
                                               READ;
                iresp_ready_o = is_hit && !ireq_kill_i;      // Next request overlaps the answer
                iresp_valid_o = is_hit && !ireq_kill_i;
                rd_en         = is_hit && !ireq_kill_i && ireq_valid_i;
            end
            MISS: begin
                state_d     = ireq_kill_i ? KILL     :
                              ifill_ack_i ? FILL_END :
                                            MISS;
                miss_o      = 1'b1;
                ifill_req_o = 1'b1;                          // Held until ack is seen
                wr_en       = ifill_ack_i;
            end
            FILL_END: begin
                state_d = ireq_kill_i  ? KILL     :
                          !ifill_ack_i ? REPLAY   :
                                         FILL_END;
            end
            REPLAY: begin
                state_d   = ireq_kill_i ? READ : LOOKUP;
                rd_en     = !ireq_kill_i;
                rd_replay = 1'b1;
            end
            KILL: begin
                // Handshake still runs to the end and the line is kept
                state_d     = (fill_done_q && !ifill_ack_i) ? READ : KILL;
                ifill_req_o = !fill_done_q;
                wr_en       = ifill_ack_i && !fill_done_q;
            end
            default: begin
                state_d = READ;
            end
        endcase
    end

    // Way select on the hit vector and word select on the offset
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (arr.hit[w]) hit_line = arr.rd_lines[w];
        end
    end

    assign iresp_data_o = line_word(hit_line, addr_q[OFS_W-1 -: WSEL_W]);

    assign rd_addr      = rd_replay ? addr_q : ireq_addr_i;
    assign arr.rd_en    = rd_en;
    assign arr.rd_idx   = rd_addr[OFS_W +: IDX_W];
    assign arr.rd_tag   = rd_addr[ADDR_W-1 -: TAG_W];
    assign arr.wr_en    = wr_en;
    assign arr.wr_idx   = addr_q[OFS_W +: IDX_W];
    assign arr.wr_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign arr.wr_way   = way_q;
    assign arr.wr_line  = ifill_data_i;
    assign arr.flush    = flush_en;

    assign ifill_addr_o = line_base(addr_q);     // Line aligned

endmodule

`default_nettype wire

/* hw/icache_ctrl_pkg.sv */
`default_nettype none

package icache_ctrl_pkg;

    import icache_cfg_pkg::*;

    typedef enum logic [2:0] {
        READ     = 3'b000,  // Idle and taking new requests
        LOOKUP   = 3'b001,  // Tag and data results are back
        MISS     = 3'b010,  // Fill request is up
        FILL_END = 3'b011,  // Wait for ack to drop
        REPLAY   = 3'b100,  // Re-read after the fill
        KILL     = 3'b101   // Finish a cancelled fill
    } ictrl_state_t;

    // Address of the first byte of the line holding addr
    function automatic paddr_t line_base(paddr_t addr);
        return {addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    endfunction

    function automatic word_t line_word(line_t line, word_sel_t sel);
        return line[sel*WORD_W +: WORD_W];
    endfunction

endpackage

`default_nettype wire

/* hw/icache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  logic            clk_i,
    icache_array_if.data    arr
);

    import icache_cfg_pkg::*;

    line_t                    mem_q [ICACHE_N_SET][ICACHE_N_WAY];
    line_t [ICACHE_N_WAY-1:0] rd_lines_q;

    // Whole line is written in one go from the fill channel
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (arr.wr_en && arr.wr_way[w]) begin
                mem_q[arr.wr_idx][w] <= arr.wr_line;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr.rd_en) begin
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                rd_lines_q[w] <= mem_q[arr.rd_idx][w];    // Both ways read side by side
            end
        end
    end

    assign arr.rd_lines = rd_lines_q;

endmodule

`default_nettype wire

/* hw/icache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
    input  logic            clk_i,
    input  logic            rstn_i,
    icache_array_if.tag     arr
);

    import icache_cfg_pkg::*;

    tag_t                         tag_q [ICACHE_N_SET][ICACHE_N_WAY];
    way_vec_t [ICACHE_N_SET-1:0]  valid_q;
    logic [ICACHE_N_SET-1:0]      repl_q;      // Way to evict next in each set
    way_vec_t                     hit_d;
    way_vec_t                     hit_q;
    way_vec_t                     victim_d;
    way_vec_t                     victim_q;

    always_comb begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            hit_d[w] = valid_q[arr.rd_idx][w] && (tag_q[arr.rd_idx][w] == arr.rd_tag);
        end
    end

    // An empty way is taken before the replacement bit is asked
    always_comb begin
        victim_d = '0;
        for (int w = ICACHE_N_WAY-1; w >= 0; w--) begin
            if (!valid_q[arr.rd_idx][w]) victim_d = way_vec_t'(1) << w;
        end
        if (victim_d == '0) victim_d = way_vec_t'(1) << repl_q[arr.rd_idx];
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (arr.wr_en && arr.wr_way[w]) tag_q[arr.wr_idx][w] <= arr.wr_tag;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q  <= '0;
            repl_q   <= '0;
            hit_q    <= '0;
            victim_q <= '0;
        end else begin
            if (arr.flush) begin
                valid_q <= '0;                                     // Drop every line
            end else if (arr.wr_en) begin
                valid_q[arr.wr_idx] <= valid_q[arr.wr_idx] | arr.wr_way;
                repl_q[arr.wr_idx]  <= arr.wr_way[0];              // Point at the other way
            end
            if (arr.rd_en) begin
                hit_q    <= hit_d;
                victim_q <= victim_d;
                if (|hit_d) repl_q[arr.rd_idx] <= hit_d[0];        // Hit way becomes MRU
            end
        end
    end

    assign arr.hit    = hit_q;
    assign arr.victim = victim_q;

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // Core side
    input  logic                   ireq_valid_i,
    input  icache_cfg_pkg::paddr_t ireq_addr_i,
    input  logic                   ireq_kill_i,
    input  logic                   flush_i,
    output logic                   iresp_ready_o,
    output logic                   iresp_valid_o,
    output icache_cfg_pkg::word_t  iresp_data_o,
    output logic                   miss_o,
    // Fill side with four-phase req/ack
    output logic                   ifill_req_o,
    output icache_cfg_pkg::paddr_t ifill_addr_o,
    input  logic                   ifill_ack_i,
    input  icache_cfg_pkg::line_t  ifill_data_i
);

    icache_array_if arr_if ();

    icache_ctrl icache_ctrl_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .ireq_valid_i  (ireq_valid_i),
        .ireq_addr_i   (ireq_addr_i),
        .ireq_kill_i   (ireq_kill_i),
        .flush_i       (flush_i),
        .iresp_ready_o (iresp_ready_o),
        .iresp_valid_o (iresp_valid_o),
        .iresp_data_o  (iresp_data_o),
        .miss_o        (miss_o),
        .ifill_req_o   (ifill_req_o),
        .ifill_addr_o  (ifill_addr_o),
        .ifill_ack_i   (ifill_ack_i),
        .ifill_data_i  (ifill_data_i),
        .arr           (arr_if.ctrl)
    );

    icache_tag_array icache_tag_array_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .arr    (arr_if.tag)
    );

    icache_data_array icache_data_array_i (
        .clk_i (clk_i),
        .arr   (arr_if.data)
    );

endmodule

`default_nettype wire

/* icache_sys.f */
hw/icache_cfg_pkg.sv
hw/icache_ctrl_pkg.sv
hw/icache_array_if.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/icache_top.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_icache -f icache_sys.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_icache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* testbench/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    import icache_cfg_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          CYCLE_BUDGET = 1000;  // About 50 accesses with up to 14 cycles per miss
    localparam int          WATCHDOG_NS  = CYCLE_BUDGET * CLK_PERIOD;
    localparam int          RESP_LIMIT   = 40;    // Cycles one access may take
    localparam logic [31:0] SEED         = 32'h5c26_1d29;
    localparam word_t       DATA_MASK    = 32'hA5A5_0000;

    logic   clk_i;
    logic   rstn_i;
    logic   ireq_valid_i;
    paddr_t ireq_addr_i;
    logic   ireq_kill_i;
    logic   flush_i;
    logic   iresp_ready_o;
    logic   iresp_valid_o;
    word_t  iresp_data_o;
    logic   miss_o;
    logic   ifill_req_o;
    paddr_t ifill_addr_o;
    logic   ifill_ack_i;
    line_t  ifill_data_i;

    int     fill_count;       // Rising edges of the fill request
    paddr_t last_fill_addr;
    int     resp_count;
    int     miss_cycles;
    logic   prev_req;
    logic   prev_ack;
    paddr_t prev_fill_addr;

    // Expected tag state with two ways and one replacement bit per set
    tag_t   ref_tag   [ICACHE_N_SET][2];
    logic   ref_valid [ICACHE_N_SET][2];
    logic   ref_repl  [ICACHE_N_SET];

    int     errors;
    int     errors_at_start;
    int     checks;
    int     tests_run;
    int     tests_failing;

    icache_top icache_top_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .ireq_valid_i  (ireq_valid_i),
        .ireq_addr_i   (ireq_addr_i),
        .ireq_kill_i   (ireq_kill_i),
        .flush_i       (flush_i),
        .iresp_ready_o (iresp_ready_o),
        .iresp_valid_o (iresp_valid_o),
        .iresp_data_o  (iresp_data_o),
        .miss_o        (miss_o),
        .ifill_req_o   (ifill_req_o),
        .ifill_addr_o  (ifill_addr_o),
        .ifill_ack_i   (ifill_ack_i),
        .ifill_data_i  (ifill_data_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("error %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        int n;
        n = errors - errors_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failing++;
            $display("test %-14s FAILED with %0d errors", name, n);
        end
        errors_at_start = errors;
    endtask

    function automatic paddr_t make_addr(int tag, int idx, int word);
        return paddr_t'((tag << (IDX_W + OFS_W)) | (idx << OFS_W) | (word << 2));
    endfunction

    function automatic paddr_t line_addr_of(paddr_t addr);
        return addr & ~paddr_t'(LINE_W/8 - 1);
    endfunction

    // Word at byte address A is A XOR the mask
    function automatic word_t expected_word(paddr_t addr);
        return (32'(addr) & ~32'h3) ^ DATA_MASK;
    endfunction

    function automatic line_t fill_line(paddr_t base);
        line_t data;
        for (int k = 0; k < ICACHE_WORDS_PER_LINE; k++) begin
            data[k*WORD_W +: WORD_W] = (32'(base) + 32'(4 * k)) ^ DATA_MASK;
        end
        return data;
    endfunction

    function automatic logic predict_hit(paddr_t addr);
        tag_t t;
        idx_t s;
        logic hit;
        t   = addr[ADDR_W-1 -: TAG_W];
        s   = addr[OFS_W +: IDX_W];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                hit         = 1'b1;
                ref_repl[s] = (w == 0);   // Other way goes next
            end
        end
        return hit;
    endfunction

    function automatic void record_fill(paddr_t addr);
        idx_t s;
        int   w;
        s = addr[OFS_W +: IDX_W];
        if (!ref_valid[s][0])      w = 0;
        else if (!ref_valid[s][1]) w = 1;
        else                       w = ref_repl[s] ? 1 : 0;
        ref_tag[s][w]   = addr[ADDR_W-1 -: TAG_W];
        ref_valid[s][w] = 1'b1;
        ref_repl[s]     = (w == 0);
    endfunction

    function automatic void clear_valid_bits(logic with_repl);
        for (int s = 0; s < ICACHE_N_SET; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
            if (with_repl) ref_repl[s] = 1'b0;
        end
    endfunction

    // Fill channel checks and counters sampled mid-cycle
    initial begin : fill_monitor
        fill_count  = 0;
        resp_count  = 0;
        miss_cycles = 0;
        prev_req    = 1'b0;
        prev_ack    = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rstn_i) begin
                if (ifill_req_o && !prev_req) begin
                    fill_count++;
                    last_fill_addr = ifill_addr_o;
                    expect_true(!prev_ack, "fill request rose while acknowledge was high");
                end
                if (prev_req && !ifill_req_o)
                    expect_true(prev_ack, "fill request fell before acknowledge");
                if (prev_req && ifill_req_o)
                    expect_true(ifill_addr_o == prev_fill_addr, $sformatf(
                        "fill address moved from %h to %h", prev_fill_addr, ifill_addr_o));
                if (miss_o) begin
                    miss_cycles++;
                    expect_true(ifill_req_o, "miss indication without fill request");
                end
                if (iresp_valid_o) resp_count++;
            end
            prev_req       = ifill_req_o;
            prev_ack       = ifill_ack_i;
            prev_fill_addr = ifill_addr_o;
        end
    end

    initial begin : memory_model
        int     delay;
        paddr_t addr;
        ifill_ack_i  = 1'b0;
        ifill_data_i = '0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && ifill_req_o && !ifill_ack_i) begin
                addr  = ifill_addr_o;
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk_i);
                @(posedge clk_i);
                #1;
                ifill_data_i = fill_line(addr);
                ifill_ack_i  = 1'b1;
                do @(negedge clk_i); while (ifill_req_o);
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk_i);
                @(posedge clk_i);
                #1;
                ifill_ack_i = 1'b0;
            end
        end
    end

    // Starts and ends 1 ns after a rising edge
    task automatic fetch(input paddr_t addr, output word_t data, output int latency,
                         output logic got);
        int cycles;
        ireq_valid_i = 1'b1;
        ireq_addr_i  = addr;
        cycles       = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!iresp_ready_o && cycles < RESP_LIMIT);
        @(posedge clk_i);            // Accepted here
        #1;
        ireq_valid_i = 1'b0;
        latency      = 0;
        got          = 1'b0;
        data         = '0;
        while (!got && latency < RESP_LIMIT) begin
            @(negedge clk_i);
            latency++;
            if (iresp_valid_o) begin
                got  = 1'b1;
                data = iresp_data_o;
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic verify_access(input paddr_t addr);
        logic  exp_hit;
        logic  got;
        word_t data;
        int    latency;
        int    fills0;
        int    misses0;
        fills0  = fill_count;
        misses0 = miss_cycles;
        exp_hit = predict_hit(addr);
        if (!exp_hit) record_fill(addr);
        fetch(addr, data, latency, got);
        expect_true(got, $sformatf("no response for address %h", addr));
        expect_true(data == expected_word(addr), $sformatf("address %h read %h, expected %h",
            addr, data, expected_word(addr)));
        if (exp_hit) begin
            expect_true(fill_count == fills0, $sformatf("hit on %h made a fill request", addr));
            expect_true(latency == 1, $sformatf("hit on %h took %0d cycles", addr, latency));
            expect_true(miss_cycles == misses0, $sformatf("hit on %h raised miss", addr));
        end else begin
            expect_true(fill_count == fills0 + 1, $sformatf("miss on %h made %0d fill requests",
                addr, fill_count - fills0));
            expect_true(last_fill_addr == line_addr_of(addr), $sformatf(
                "fill address %h for %h", last_fill_addr, addr));
            expect_true(miss_cycles > misses0, $sformatf("miss on %h without miss_o", addr));
        end
    endtask

    // Second request is accepted while the first one is answered
    task automatic back_to_back(input paddr_t addr_a, input paddr_t addr_b);
        logic  got_a;
        logic  got_b;
        logic  ready_a;
        word_t data_a;
        word_t data_b;
        int    fills0;
        fills0 = fill_count;
        void'(predict_hit(addr_a));
        void'(predict_hit(addr_b));
        ireq_valid_i = 1'b1;
        ireq_addr_i  = addr_a;
        @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ireq_addr_i = addr_b;
        @(negedge clk_i);
        got_a   = iresp_valid_o;
        data_a  = iresp_data_o;
        ready_a = iresp_ready_o;
        @(posedge clk_i);
        #1;
        ireq_valid_i = 1'b0;
        @(negedge clk_i);
        got_b  = iresp_valid_o;
        data_b = iresp_data_o;
        @(posedge clk_i);
        #1;
        expect_true(got_a && ready_a, "first burst hit not answered or not ready");
        expect_true(got_b, "second burst hit not answered on the next cycle");
        expect_true(data_a == expected_word(addr_a), $sformatf("burst read %h for %h",
            data_a, addr_a));
        expect_true(data_b == expected_word(addr_b), $sformatf("burst read %h for %h",
            data_b, addr_b));
        expect_true(fill_count == fills0, "burst hits made a fill request");
    endtask

    task automatic kill_in_lookup(input paddr_t addr);
        int fills0;
        int resps0;
        fills0 = fill_count;
        resps0 = resp_count;
        void'(predict_hit(addr));
        ireq_valid_i = 1'b1;
        ireq_addr_i  = addr;
        @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ireq_valid_i = 1'b0;
        ireq_kill_i  = 1'b1;
        @(posedge clk_i);
        #1;
        ireq_kill_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        expect_true(resp_count == resps0, $sformatf("killed lookup of %h answered", addr));
        expect_true(fill_count == fills0, $sformatf("killed lookup of %h started a fill", addr));
    endtask

    task automatic kill_in_miss(input paddr_t addr);
        int fills0;
        int resps0;
        int cycles;
        fills0 = fill_count;
        resps0 = resp_count;
        void'(predict_hit(addr));
        record_fill(addr);                 // Line is still written
        ireq_valid_i = 1'b1;
        ireq_addr_i  = addr;
        @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ireq_valid_i = 1'b0;
        cycles       = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!miss_o && cycles < RESP_LIMIT);
        @(posedge clk_i);
        #1;
        ireq_kill_i = 1'b1;
        @(posedge clk_i);
        #1;
        ireq_kill_i = 1'b0;
        cycles      = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while ((ifill_req_o || ifill_ack_i) && cycles < RESP_LIMIT);
        expect_true(cycles < RESP_LIMIT, "killed fill handshake never completed");
        repeat (2) @(posedge clk_i);
        #1;
        expect_true(resp_count == resps0, $sformatf("killed miss on %h answered", addr));
        expect_true(fill_count == fills0 + 1, "killed miss did not make one fill request");
    endtask

    // A request presented with the flush must not be taken
    task automatic flush_cache(input paddr_t probe);
        int fills0;
        int resps0;
        fills0       = fill_count;
        resps0       = resp_count;
        flush_i      = 1'b1;
        ireq_valid_i = 1'b1;
        ireq_addr_i  = probe;
        @(negedge clk_i);
        expect_true(!iresp_ready_o, "ready high during flush");
        @(posedge clk_i);
        #1;
        flush_i      = 1'b0;
        ireq_valid_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        expect_true(fill_count == fills0 && resp_count == resps0,
            "request presented with flush was accepted");
        clear_valid_bits(1'b0);
    endtask

    initial begin : main
        paddr_t cold [3];
        paddr_t rep [3];
        int     order [8];
        int     s;
        int     t;
        int     fills0;
        void'($urandom(SEED));
        order           = '{0, 1, 0, 2, 0, 1, 2, 1};
        rstn_i          = 1'b0;
        ireq_valid_i    = 1'b0;
        ireq_addr_i     = '0;
        ireq_kill_i     = 1'b0;
        flush_i         = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failing   = 0;
        clear_valid_bits(1'b1);
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        @(negedge clk_i);
        expect_true(!iresp_valid_o && !ifill_req_o && !miss_o, "outputs active after reset");
        expect_true(iresp_ready_o, "not ready after reset");
        @(posedge clk_i);
        #1;
        report_test("reset");

        for (int i = 0; i < 3; i++) begin
            cold[i] = make_addr($urandom_range(399, 320), i, $urandom_range(3, 0));
            verify_access(cold[i]);
        end
        report_test("cold_miss");

        verify_access(cold[0]);
        verify_access(cold[0] ^ paddr_t'(4));    // Other words of the same line
        verify_access(cold[0] ^ paddr_t'(8));
        verify_access(cold[1]);
        verify_access(cold[2] ^ paddr_t'(12));
        back_to_back(cold[0], cold[1]);
        back_to_back(cold[2], cold[2] ^ paddr_t'(4));
        report_test("hit");

        // Small tag range so lines get reused and evicted
        for (int i = 0; i < 24; i++) begin
            verify_access(make_addr($urandom_range(3, 0), $urandom_range(7, 0),
                                    $urandom_range(3, 0)));
        end
        report_test("fill_protocol");

        s      = $urandom_range(7, 0);
        t      = $urandom_range(200, 8);
        rep[0] = make_addr(t, s, 0);
        t      = t + 1 + $urandom_range(50, 0);
        rep[1] = make_addr(t, s, 1);
        t      = t + 1 + $urandom_range(50, 0);
        rep[2] = make_addr(t, s, 3);
        foreach (order[i]) verify_access(rep[order[i]]);
        report_test("replacement");

        kill_in_lookup(rep[1]);
        kill_in_lookup(make_addr(450, s, 0));
        kill_in_miss(make_addr(451, s, 0));
        verify_access(make_addr(451, s, 2));
        report_test("kill");

        flush_cache(cold[0]);
        fills0 = fill_count;
        verify_access(cold[0]);
        verify_access(cold[1]);
        verify_access(cold[2]);
        verify_access(rep[1]);
        expect_true(fill_count == fills0 + 4, "cached lines survived the flush");
        report_test("flush");

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 tests_run, tests_failing, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
